// ==== call_arb/call_dispatch.sv ====
// issues at most one call per cycle to the children
// parked calls go first, round-robin over children that are ready
// a slot call goes out directly only when nothing was dequeued, its child
// is ready and its child has nothing parked, so per-child order holds
// decision is combinational, call_vld_o/call_o are registered
`timescale 1ns/100ps
`default_nettype none

`include "call_arb_settings.svh"

module call_dispatch (
    input  wire                                          clk,
    input  wire                                          rstn,
    input  wire  [`CA_GROUPS-1:0]                        slot_vld_i,
    input  wire  call_arb_pkg::call_out_t [`CA_GROUPS-1:0] slot_i,
    output logic [`CA_GROUPS-1:0]                        slot_take_o,
    input  wire  [`CA_CHILDREN-1:0]                      child_rdy_i,
    input  wire  [`CA_CHILDREN-1:0]                      q_nonempty_i,
    input  wire  [`CA_CHILDREN-1:0]                      q_full_i,
    input  wire  call_arb_pkg::call_out_t [`CA_CHILDREN-1:0] head_i,
    output logic                                         push_o,
    output call_arb_pkg::child_idx_t                     push_child_o,
    output call_arb_pkg::call_out_t                      push_data_o,
    output logic                                         pop_o,
    output call_arb_pkg::child_idx_t                     pop_child_o,
    output logic                                         call_vld_o,
    output call_arb_pkg::call_out_t                      call_o
);

    localparam int GRP_W = (`CA_GROUPS > 1) ? $clog2(`CA_GROUPS) : 1;

    logic                     deq_vld;
    call_arb_pkg::child_idx_t deq_idx;
    logic                     grp_vld;
    logic [GRP_W-1:0]         grp_idx;
    call_arb_pkg::call_out_t  sel;
    call_arb_pkg::child_idx_t sel_child;
    logic                     direct;

    // dequeue side, only children that can take a call now
    rr_picker #(
        .N          (`CA_CHILDREN)
    ) i_rr_deq (
        .clk        (clk),
        .rstn       (rstn),
        .req_i      (q_nonempty_i & child_rdy_i),
        .advance_i  (deq_vld),
        .grant_vld_o(deq_vld),
        .grant_o    (deq_idx)
    );

    // group side moves on every grant, so a slot stuck on a full
    // FIFO does not starve the other group
    rr_picker #(
        .N          (`CA_GROUPS)
    ) i_rr_grp (
        .clk        (clk),
        .rstn       (rstn),
        .req_i      (slot_vld_i),
        .advance_i  (grp_vld),
        .grant_vld_o(grp_vld),
        .grant_o    (grp_idx)
    );

    assign sel       = slot_i[grp_idx];
    assign sel_child = sel.req.child;

    assign pop_o        = deq_vld;
    assign pop_child_o  = deq_idx;
    assign push_child_o = sel_child;
    assign push_data_o  = sel;

    always_comb begin
        direct      = 1'b0;
        push_o      = 1'b0;
        slot_take_o = '0;
        if (grp_vld) begin
            if (!deq_vld && child_rdy_i[sel_child] && !q_nonempty_i[sel_child]) begin
                direct = 1'b1;
            end else if (!q_full_i[sel_child]) begin
                push_o = 1'b1;
            end
            // a full FIFO leaves the slot in place
            slot_take_o[grp_idx] = direct | push_o;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            call_vld_o <= 1'b0;
        end else begin
            call_vld_o <= deq_vld | direct;
        end
    end

    always_ff @(posedge clk) begin
        if (deq_vld) begin
            call_o <= head_i[deq_idx];
        end else if (direct) begin
            call_o <= sel;
        end
    end

endmodule

`default_nettype wire

// ==== call_arb/call_group.sv ====
// one parent group: a one-entry buffer per parent and one group slot
// call_rdy_o[p] is high while buffer p is empty
// the slot refills one edge after a buffer is picked, and only when
// the slot is empty or taken in the same cycle
// GROUP_BASE is the parent number of local port 0
`timescale 1ns/100ps
`default_nettype none

`include "call_arb_settings.svh"

module call_group #(
    parameter int GROUP_BASE = 0
) (
    input  wire                                          clk,
    input  wire                                          rstn,
    input  wire  [`CA_PER_GROUP-1:0]                     call_vld_i,
    input  wire  call_arb_pkg::call_req_t [`CA_PER_GROUP-1:0] call_req_i,
    output logic [`CA_PER_GROUP-1:0]                     call_rdy_o,
    input  wire                                          slot_take_i,
    output logic                                         slot_vld_o,
    output call_arb_pkg::call_out_t                      slot_o
);

    localparam int PICK_W = $clog2(`CA_PER_GROUP);

    logic [`CA_PER_GROUP-1:0]                     buf_vld;
    call_arb_pkg::call_req_t [`CA_PER_GROUP-1:0] buf_req;
    logic                                         pick_vld;
    logic [PICK_W-1:0]                            pick_idx;
    logic                                         slot_free;
    logic                                         load;

    assign call_rdy_o = ~buf_vld;

    // slot may take a new call if it drains this cycle
    assign slot_free = ~slot_vld_o | slot_take_i;
    assign load      = slot_free & pick_vld;

    rr_picker #(
        .N          (`CA_PER_GROUP)
    ) i_rr_picker (
        .clk        (clk),
        .rstn       (rstn),
        .req_i      (buf_vld),
        .advance_i  (load),
        .grant_vld_o(pick_vld),
        .grant_o    (pick_idx)
    );

    // a buffer fills only when empty and drains only when full,
    // so the two cases never meet on one entry
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_vld <= '0;
        end else begin
            for (int p = 0; p < `CA_PER_GROUP; p++) begin
                if (call_vld_i[p] && call_rdy_o[p]) begin
                    buf_vld[p] <= 1'b1;
                end else if (load && (pick_idx == PICK_W'(p))) begin
                    buf_vld[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `CA_PER_GROUP; p++) begin
            if (call_vld_i[p] && call_rdy_o[p]) begin
                buf_req[p] <= call_req_i[p];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot_vld_o <= 1'b0;
        end else if (slot_free) begin
            slot_vld_o <= pick_vld;
        end
    end

    // payload with the global parent number stamped on
    always_ff @(posedge clk) begin
        if (load) begin
            slot_o.req    <= buf_req[pick_idx];
            slot_o.parent <= call_arb_pkg::parent_idx_t'(GROUP_BASE + int'(pick_idx));
        end
    end

endmodule

`default_nettype wire

// ==== call_arb/child_queue.sv ====
// parked calls, one circular FIFO per child
// one push and one pop per cycle, to the same child or to different ones
// a push shows in q_nonempty_o and head_o after one edge
// the caller must not push to a full FIFO or pop an empty one
`timescale 1ns/100ps
`default_nettype none

`include "call_arb_settings.svh"

module child_queue (
    input  wire                                             clk,
    input  wire                                             rstn,
    input  wire                                             push_i,
    input  wire  call_arb_pkg::child_idx_t                  push_child_i,
    input  wire  call_arb_pkg::call_out_t                   push_data_i,
    input  wire                                             pop_i,
    input  wire  call_arb_pkg::child_idx_t                  pop_child_i,
    output logic [`CA_CHILDREN-1:0]                         q_nonempty_o,
    output logic [`CA_CHILDREN-1:0]                         q_full_o,
    output call_arb_pkg::call_out_t [`CA_CHILDREN-1:0]      head_o
);

    localparam int DEPTH = `CA_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    call_arb_pkg::call_out_t mem [`CA_CHILDREN][DEPTH];
    logic [PTR_W-1:0]        wr_ptr [`CA_CHILDREN];
    logic [PTR_W-1:0]        rd_ptr [`CA_CHILDREN];
    logic [CNT_W-1:0]        count [`CA_CHILDREN];
    logic [`CA_CHILDREN-1:0] push_sel;
    logic [`CA_CHILDREN-1:0] pop_sel;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // one-hot decode of the target FIFOs
    always_comb begin
        push_sel = '0;
        pop_sel  = '0;
        if (push_i) begin
            push_sel[push_child_i] = 1'b1;
        end
        if (pop_i) begin
            pop_sel[pop_child_i] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int c = 0; c < `CA_CHILDREN; c++) begin
                wr_ptr[c] <= '0;
                rd_ptr[c] <= '0;
                count[c]  <= '0;
            end
        end else begin
            for (int c = 0; c < `CA_CHILDREN; c++) begin
                if (push_sel[c]) begin
                    wr_ptr[c] <= ptr_next(wr_ptr[c]);
                end
                if (pop_sel[c]) begin
                    rd_ptr[c] <= ptr_next(rd_ptr[c]);
                end
                // push and pop together leave the count unchanged
                count[c] <= count[c] + CNT_W'(push_sel[c]) - CNT_W'(pop_sel[c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[push_child_i][wr_ptr[push_child_i]] <= push_data_i;
        end
    end

    always_comb begin
        for (int c = 0; c < `CA_CHILDREN; c++) begin
            head_o[c]       = mem[c][rd_ptr[c]];
            q_nonempty_o[c] = (count[c] != '0);
            q_full_o[c]     = (count[c] == CNT_W'(DEPTH));
        end
    end

endmodule

`default_nettype wire

// ==== call_arbiter.f ====
+incdir+common
common/call_arb_pkg.sv
rtl/rr_picker.sv
call_arb/call_group.sv
call_arb/child_queue.sv
call_arb/call_dispatch.sv
rtl/call_arbiter.sv
sim/call_arbiter_tb.sv

// ==== common/call_arb_pkg.sv ====
// types shared by the call arbiter blocks and its testbench
// field widths come from the settings header
// call_req_t keeps the child index in its top bits
`default_nettype none

`include "call_arb_settings.svh"

package call_arb_pkg;

    // index types
    typedef logic [$clog2(`CA_CHILDREN)-1:0] child_idx_t;
    typedef logic [$clog2(`CA_PARENTS)-1:0]  parent_idx_t;
    typedef logic [$clog2(`CA_THREADS)-1:0]  thread_idx_t;

    // one call as sent by a parent
    typedef struct packed {
        child_idx_t                            child;
        thread_idx_t                           thread;
        logic                                  ret_req;
        logic [`CA_PC_W-1:0]                   pc;
        logic [`CA_ARG_NUM-1:0][`CA_ARG_W-1:0] args;
    } call_req_t;

    // call as issued to a child, stamped with its source parent
    typedef struct packed {
        parent_idx_t parent;
        call_req_t   req;
    } call_out_t;

endpackage

`default_nettype wire

// ==== common/call_arb_settings.svh ====
// counts and field widths for the call arbiter
// CA_PARENTS must equal CA_GROUPS * CA_PER_GROUP
// CA_CHILDREN, CA_THREADS and CA_PER_GROUP must be at least 2
// CA_QUEUE_DEPTH need not be a power of two

`ifndef CALL_ARB_SETTINGS_SVH
`define CALL_ARB_SETTINGS_SVH

// parent side
`define CA_PARENTS      8
`define CA_GROUPS       2
`define CA_PER_GROUP    4

// child side
`define CA_CHILDREN     4
// parked calls held per child
`define CA_QUEUE_DEPTH  4

// call fields
`define CA_THREADS      4
`define CA_ARG_W        16
`define CA_ARG_NUM      2
`define CA_PC_W         16

`endif

// ==== rtl/call_arbiter.sv ====
// call arbiter top, eight parents in two groups onto four children
// idle latency from call_vld_i/call_rdy_o handshake to call_vld_o is
// three edges; under contention call_vld_o alone marks the issue
// child_rdy_i high means the child takes a call issued on the next edge
`timescale 1ns/100ps
`default_nettype none

`include "call_arb_settings.svh"

module call_arbiter (
    input  wire                                           clk,
    input  wire                                           rstn,
    input  wire  [`CA_PARENTS-1:0]                        call_vld_i,
    input  wire  call_arb_pkg::call_req_t [`CA_PARENTS-1:0] call_req_i,
    output logic [`CA_PARENTS-1:0]                        call_rdy_o,
    input  wire  [`CA_CHILDREN-1:0]                       child_rdy_i,
    output logic                                          call_vld_o,
    output call_arb_pkg::call_out_t                       call_o
);

    logic [`CA_GROUPS-1:0]                         slot_vld;
    call_arb_pkg::call_out_t [`CA_GROUPS-1:0]     slot;
    logic [`CA_GROUPS-1:0]                         slot_take;
    logic                                          push;
    call_arb_pkg::child_idx_t                      push_child;
    call_arb_pkg::call_out_t                       push_data;
    logic                                          pop;
    call_arb_pkg::child_idx_t                      pop_child;
    logic [`CA_CHILDREN-1:0]                       q_nonempty;
    logic [`CA_CHILDREN-1:0]                       q_full;
    call_arb_pkg::call_out_t [`CA_CHILDREN-1:0]   head;

    for (genvar g = 0; g < `CA_GROUPS; g++) begin : g_group
        call_group #(
            .GROUP_BASE (g * `CA_PER_GROUP)
        ) i_call_group (
            .clk        (clk),
            .rstn       (rstn),
            .call_vld_i (call_vld_i[g*`CA_PER_GROUP +: `CA_PER_GROUP]),
            .call_req_i (call_req_i[g*`CA_PER_GROUP +: `CA_PER_GROUP]),
            .call_rdy_o (call_rdy_o[g*`CA_PER_GROUP +: `CA_PER_GROUP]),
            .slot_take_i(slot_take[g]),
            .slot_vld_o (slot_vld[g]),
            .slot_o     (slot[g])
        );
    end

    child_queue i_child_queue (
        .clk         (clk),
        .rstn        (rstn),
        .push_i      (push),
        .push_child_i(push_child),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_child_i (pop_child),
        .q_nonempty_o(q_nonempty),
        .q_full_o    (q_full),
        .head_o      (head)
    );

    call_dispatch i_call_dispatch (
        .clk         (clk),
        .rstn        (rstn),
        .slot_vld_i  (slot_vld),
        .slot_i      (slot),
        .slot_take_o (slot_take),
        .child_rdy_i (child_rdy_i),
        .q_nonempty_i(q_nonempty),
        .q_full_i    (q_full),
        .head_i      (head),
        .push_o      (push),
        .push_child_o(push_child),
        .push_data_o (push_data),
        .pop_o       (pop),
        .pop_child_o (pop_child),
        .call_vld_o  (call_vld_o),
        .call_o      (call_o)
    );

endmodule

`default_nettype wire

// ==== rtl/rr_picker.sv ====
// round-robin picker over N request lines
// the search starts at the pointer; the pointer only moves on advance_i
// with a valid grant, to one past the granted line
// grant_o is combinational from req_i and the pointer
`timescale 1ns/100ps
`default_nettype none

module rr_picker #(
    parameter int N = 4,
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1
) (
    input  wire              clk,
    input  wire              rstn,
    input  wire  [N-1:0]     req_i,
    input  wire              advance_i,
    output logic             grant_vld_o,
    output logic [IDX_W-1:0] grant_o
);

    logic [IDX_W-1:0] ptr;

    // walk downward so the line closest to the pointer wins
    always_comb begin
        grant_vld_o = 1'b0;
        grant_o     = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (req_i[(int'(ptr) + i) % N]) begin
                grant_vld_o = 1'b1;
                grant_o     = IDX_W'((int'(ptr) + i) % N);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptr <= '0;
        end else if (advance_i && grant_vld_o) begin
            ptr <= (grant_o == IDX_W'(N - 1)) ? '0 : grant_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== sim/call_arbiter_tb.sv ====
// testbench for the call arbiter
// rows run in order; a row marked WITH is driven in the same cycle as
// the row after it, so such rows must name different parents
// inputs change on the falling clock edge, outputs are sampled there too
// the scoreboard keeps one expected queue per parent and child pair
`timescale 1ns/100ps
`default_nettype none

`include "call_arb_settings.svh"

module call_arbiter_tb;

    // what happens after a row is driven
    localparam int NEXT  = 0;
    localparam int WITH  = 1;
    localparam int DRAIN = 2;
    localparam int LONE  = 3;
    localparam int HOLD  = 4;
    localparam int ROWS  = 30;
    localparam int LIMIT = ROWS * 40;
    localparam int KEYS  = `CA_PARENTS * `CA_CHILDREN;

    typedef struct {
        int         parent;
        int         child;
        int         thread;
        bit         ret_req;
        int         pc;
        logic [3:0] rdy;
        int         step;
    } row_t;

    logic                                      clk = 1'b0;
    logic                                      rstn;
    logic [`CA_PARENTS-1:0]                    call_vld_i;
    call_arb_pkg::call_req_t [`CA_PARENTS-1:0] call_req_i;
    logic [`CA_PARENTS-1:0]                    call_rdy_o;
    logic [`CA_CHILDREN-1:0]                   child_rdy_i;
    logic                                      call_vld_o;
    call_arb_pkg::call_out_t                   call_o;

    call_arb_pkg::call_out_t exp_q [KEYS][$];
    int                      cyc_q [KEYS][$];
    bit                      lat_q [KEYS][$];
    logic [`CA_CHILDREN-1:0] rdy_q;
    call_arb_pkg::call_out_t last_out;
    call_arb_pkg::call_out_t exp_call;
    int                      key;
    int                      seed;
    int                      cyc = 0;
    int                      in_cnt = 0;
    int                      out_cnt = 0;
    int                      err_cnt = 0;
    int                      fail_cnt = 0;
    int                      blocked;
    int                      i;
    int                      j;

    // parent, child, thread, ret_req, pc, child_rdy, step
    row_t tbl [ROWS] = '{
        // lone calls with everything idle
        '{1, 2, 1, 1, 'h0100, 4'b1111, LONE},
        '{6, 0, 3, 0, 'h0101, 4'b1111, LONE},
        // child 1 busy, calls from parent 0 park until it is released
        '{0, 1, 0, 1, 'h0200, 4'b1101, NEXT},
        '{0, 1, 2, 0, 'h0201, 4'b1101, NEXT},
        '{0, 1, 1, 1, 'h0202, 4'b1101, NEXT},
        '{7, 2, 0, 0, 'h0203, 4'b1111, DRAIN},
        // parent 2 streams to child 3 while others load it
        '{2, 3, 0, 0, 'h0300, 4'b0111, WITH},
        '{0, 3, 1, 1, 'h0301, 4'b0111, WITH},
        '{4, 3, 2, 0, 'h0302, 4'b0111, NEXT},
        '{2, 3, 0, 1, 'h0303, 4'b1111, WITH},
        '{6, 3, 3, 0, 'h0304, 4'b1111, NEXT},
        '{2, 3, 1, 0, 'h0305, 4'b1111, WITH},
        '{4, 3, 2, 1, 'h0306, 4'b1111, DRAIN},
        // all eight parents at once
        '{0, 0, 0, 0, 'h0400, 4'b1111, WITH},
        '{1, 1, 1, 1, 'h0401, 4'b1111, WITH},
        '{2, 2, 2, 0, 'h0402, 4'b1111, WITH},
        '{3, 3, 3, 1, 'h0403, 4'b1111, WITH},
        '{4, 0, 0, 1, 'h0404, 4'b1111, WITH},
        '{5, 1, 1, 0, 'h0405, 4'b1111, WITH},
        '{6, 2, 2, 1, 'h0406, 4'b1111, WITH},
        '{7, 3, 3, 0, 'h0407, 4'b1111, DRAIN},
        // child 2 held until its FIFO fills and buffers back up
        '{0, 2, 0, 1, 'h0500, 4'b1011, WITH},
        '{1, 2, 1, 0, 'h0501, 4'b1011, WITH},
        '{2, 2, 2, 1, 'h0502, 4'b1011, WITH},
        '{3, 2, 3, 0, 'h0503, 4'b1011, WITH},
        '{4, 2, 0, 0, 'h0504, 4'b1011, WITH},
        '{5, 2, 1, 1, 'h0505, 4'b1011, WITH},
        '{6, 2, 2, 0, 'h0506, 4'b1011, WITH},
        '{7, 2, 3, 1, 'h0507, 4'b1011, HOLD},
        '{3, 0, 2, 1, 'h0600, 4'b1111, DRAIN}
    };

    call_arbiter i_call_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .call_vld_i (call_vld_i),
        .call_req_i (call_req_i),
        .call_rdy_o (call_rdy_o),
        .child_rdy_i(child_rdy_i),
        .call_vld_o (call_vld_o),
        .call_o     (call_o)
    );

    always #5 clk = ~clk;

    task automatic compare_call(input string name, input call_arb_pkg::call_out_t got,
                                input call_arb_pkg::call_out_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_index(input string name, input call_arb_pkg::parent_idx_t got,
                                 input call_arb_pkg::parent_idx_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_bits(input string name, input logic [`CA_PARENTS-1:0] got,
                                input logic [`CA_PARENTS-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_run;
        $display("errors: value %0d, other %0d; calls in %0d, out %0d",
                 err_cnt, fail_cnt, in_cnt, out_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // drive rows first..last together, hold each until its handshake
    task automatic send_group(input int first, input int last, input bit lat);
        logic [`CA_PARENTS-1:0]  pend;
        logic [`CA_PARENTS-1:0]  taken;
        call_arb_pkg::call_req_t reqs [`CA_PARENTS];
        call_arb_pkg::call_out_t exp;
        int                      p;
        int                      k;
        int                      d;
        pend = '0;
        child_rdy_i = tbl[first].rdy;
        for (int r = first; r <= last; r++) begin
            p = tbl[r].parent;
            reqs[p].child   = call_arb_pkg::child_idx_t'(tbl[r].child);
            reqs[p].thread  = call_arb_pkg::thread_idx_t'(tbl[r].thread);
            reqs[p].ret_req = tbl[r].ret_req;
            reqs[p].pc      = `CA_PC_W'(tbl[r].pc);
            for (int a = 0; a < `CA_ARG_NUM; a++) begin
                reqs[p].args[a] = `CA_ARG_W'($random(seed));
            end
            call_req_i[p] = reqs[p];
            pend[p] = 1'b1;
        end
        call_vld_i = pend;
        d = cyc;
        while (pend != '0) begin
            taken = pend & call_rdy_o;
            @(posedge clk);
            for (p = 0; p < `CA_PARENTS; p++) begin
                if (taken[p]) begin
                    k = p * `CA_CHILDREN + int'(reqs[p].child);
                    exp.parent = call_arb_pkg::parent_idx_t'(p);
                    exp.req    = reqs[p];
                    exp_q[k].push_back(exp);
                    cyc_q[k].push_back(d);
                    lat_q[k].push_back(lat);
                    in_cnt++;
                end
            end
            @(negedge clk);
            pend = pend & ~taken;
            call_vld_i = pend;
        end
    endtask

    task automatic wait_drain;
        @(posedge clk);
        while (out_cnt < in_cnt) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        rdy_q <= child_rdy_i;
        if (cyc >= LIMIT) begin
            $display("timeout: run stopped after %0d cycles with calls outstanding", cyc);
            fail_cnt++;
            finish_run();
        end
    end

    // output monitor and scoreboard
    always @(negedge clk) begin
        if (rstn && call_vld_o) begin
            key = int'(call_o.parent) * `CA_CHILDREN + int'(call_o.req.child);
            last_out = call_o;
            if (!rdy_q[call_o.req.child]) begin
                $display("call issued to child %0d at %0t while it was not ready",
                         call_o.req.child, $time);
                fail_cnt++;
            end
            if (exp_q[key].size() == 0) begin
                $display("unexpected call from parent %0d to child %0d at %0t",
                         call_o.parent, call_o.req.child, $time);
                fail_cnt++;
            end else begin
                exp_call = exp_q[key].pop_front();
                compare_call("call_o", call_o, exp_call);
                if (lat_q[key].pop_front()) begin
                    compare_count("call latency", cyc - cyc_q[key][0], 3);
                end
                void'(cyc_q[key].pop_front());
            end
            out_cnt++;
        end
    end

    initial begin
        seed = 92467;
        rstn = 1'b0;
        call_vld_i = '0;
        call_req_i = '0;
        child_rdy_i = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        compare_bits("call_vld_o", call_vld_o, '0);
        compare_bits("call_rdy_o", call_rdy_o, '1);
        rstn = 1'b1;
        @(negedge clk);
        compare_bits("call_vld_o", call_vld_o, '0);
        compare_bits("call_rdy_o", call_rdy_o, '1);
        i = 0;
        while (i < ROWS) begin
            j = i;
            while (j < ROWS - 1 && tbl[j].step == WITH) begin
                j++;
            end
            send_group(i, j, tbl[j].step == LONE);
            if (tbl[j].step == DRAIN || tbl[j].step == LONE) begin
                wait_drain();
            end
            if (tbl[j].step == LONE) begin
                compare_index("call_o.parent", last_out.parent,
                              call_arb_pkg::parent_idx_t'(tbl[j].parent));
                compare_index("call_o.req.child", last_out.req.child,
                              call_arb_pkg::parent_idx_t'(tbl[j].child));
            end
            if (tbl[j].step == HOLD) begin
                // one park per cycle until the FIFO is full
                repeat (2 * `CA_QUEUE_DEPTH + 4) @(negedge clk);
                blocked = in_cnt - out_cnt - `CA_QUEUE_DEPTH - `CA_GROUPS;
                if (blocked < 0) begin
                    blocked = 0;
                end
                compare_count("blocked parents", $countones(~call_rdy_o), blocked);
            end
            i = j + 1;
        end
        wait_drain();
        repeat (4) @(negedge clk);
        compare_count("calls out", out_cnt, in_cnt);
        finish_run();
    end

endmodule

`default_nettype wire
